// File: hdl/kickoff_params.svh
/* Channel count, address map and bus widths of the descriptor kick-off path */
`ifndef KICKOFF_PARAMS_SVH
`define KICKOFF_PARAMS_SVH

// Channel count and channel index width
`define KICK_NUM_CHANNELS 8
`define KICK_CHAN_BITS 3

// Wishbone address and data widths
`define KICK_ADDR_BITS 12
`define KICK_DATA_BITS 32
// Full descriptor address, HIGH and LOW words together
`define KICK_DESC_BITS 64

// Address map: bits 5..3 pick the channel, bit 2 picks HIGH or LOW
`define KICK_CHAN_LSB 3
`define KICK_HIGH_BIT 2
`define KICK_WINDOW_BYTES (8 * `KICK_NUM_CHANNELS)
`endif

// File: hdl/kickoff_pkg.sv
/* Shared types of the kick-off path: FSM state enums,
   bus command and response structs, launch stream struct */
`include "kickoff_params.svh"

package kickoff_pkg;

    // One bus command from the Wishbone adapter
    typedef struct packed {
        logic [`KICK_ADDR_BITS-1:0] addr;
        logic [`KICK_DATA_BITS-1:0] wdata;
        logic                       write;
    } kick_cmd_t;

    // Response back to the adapter
    typedef struct packed {
        logic err;
    } kick_rsp_t;

    // One launched descriptor on the outgoing stream
    typedef struct packed {
        logic [`KICK_CHAN_BITS-1:0] chan;
        logic [`KICK_DESC_BITS-1:0] addr;
    } launch_t;

    // Wishbone adapter FSM
    typedef enum logic [1:0] {
        ADP_IDLE,
        ADP_ISSUE,
        ADP_WAIT_RSP,
        ADP_FINISH
    } adapter_state_t;

    // Router FSM, LOW/HIGH pairing
    typedef enum logic [2:0] {
        RTR_IDLE,
        RTR_RESPOND_LOW,
        RTR_WAIT_HIGH,
        RTR_ROUTE,
        RTR_RESPOND_HIGH
    } router_state_t;

endpackage

// File: hdl/wb_cmd_adapter.sv
/* Wishbone classic slave front end: one bus cycle becomes one command,
   the router response comes back as a one-cycle ack or err */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module wb_cmd_adapter (
    input  logic                       clk,
    input  logic                       rst,
    // Wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`KICK_ADDR_BITS-1:0] wb_adr,
    input  logic [`KICK_DATA_BITS-1:0] wb_dat_w,
    output logic                       wb_ack,
    output logic                       wb_err,
    // Command channel toward the router
    output logic                       cmd_valid,
    input  logic                       cmd_ready,
    output kickoff_pkg::kick_cmd_t     cmd,
    // Response channel from the router
    input  logic                       rsp_valid,
    output logic                       rsp_ready,
    input  kickoff_pkg::kick_rsp_t     rsp
);

    kickoff_pkg::adapter_state_t state;
    logic                        bus_req;

    assign bus_req   = wb_cyc && wb_stb;
    assign cmd_valid = (state == kickoff_pkg::ADP_ISSUE);
    assign rsp_ready = (state == kickoff_pkg::ADP_WAIT_RSP);

    // FSM and the registered ack/err pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= kickoff_pkg::ADP_IDLE;
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            // Pulses last a single cycle
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            case (state)
                kickoff_pkg::ADP_IDLE: begin
                    if (bus_req) begin
                        state <= kickoff_pkg::ADP_ISSUE;
                    end
                end
                kickoff_pkg::ADP_ISSUE: begin
                    if (cmd_ready) begin
                        state <= kickoff_pkg::ADP_WAIT_RSP;
                    end
                end
                kickoff_pkg::ADP_WAIT_RSP: begin
                    if (rsp_valid) begin
                        wb_ack <= !rsp.err;
                        wb_err <= rsp.err;
                        state  <= kickoff_pkg::ADP_FINISH;
                    end
                end
                kickoff_pkg::ADP_FINISH: begin
                    // Host must drop stb before the next cycle is taken
                    if (!bus_req) begin
                        state <= kickoff_pkg::ADP_IDLE;
                    end
                end
                default: state <= kickoff_pkg::ADP_IDLE;
            endcase
        end
    end

    // Command capture when a request is taken in IDLE
    always_ff @(posedge clk) begin
        if (state == kickoff_pkg::ADP_IDLE && bus_req) begin
            cmd.addr  <= wb_adr;
            cmd.wdata <= wb_dat_w;
            cmd.write <= wb_we;
        end
    end

endmodule

// File: hdl/kickoff_router.sv
/* Kick-off router: channel decode, LOW/HIGH write pairing, error checks
   and hand-off of the assembled 64-bit address to the channel slot */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module kickoff_router (
    input  logic                          clk,
    input  logic                          rst,
    // Command channel from the adapter
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  kickoff_pkg::kick_cmd_t        cmd,
    // Response channel to the adapter
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output kickoff_pkg::kick_rsp_t        rsp,
    // Per-channel slot handshake, one shared address
    output logic [`KICK_NUM_CHANNELS-1:0] slot_valid,
    input  logic [`KICK_NUM_CHANNELS-1:0] slot_ready,
    output logic [`KICK_DESC_BITS-1:0]    slot_addr
);

    // First offset past the last channel register pair
    localparam logic [`KICK_ADDR_BITS-1:0] WINDOW_END = `KICK_WINDOW_BYTES;

    // ==================================================
    // Address decode
    // ==================================================

    logic [`KICK_CHAN_BITS-1:0] cmd_chan;
    logic                       cmd_high;
    logic                       cmd_in_range;
    logic                       low_ok;
    logic                       high_ok;
    logic                       cmd_fire;

    assign cmd_chan     = cmd.addr[`KICK_CHAN_LSB +: `KICK_CHAN_BITS];
    assign cmd_high     = cmd.addr[`KICK_HIGH_BIT];
    assign cmd_in_range = (cmd.addr < WINDOW_END);
    assign cmd_fire     = cmd_valid && cmd_ready;

    // ==================================================
    // State and latched transaction
    // ==================================================

    kickoff_pkg::router_state_t state;
    kickoff_pkg::router_state_t next_state;
    logic [`KICK_CHAN_BITS-1:0] lat_chan;
    logic [`KICK_DATA_BITS-1:0] low_word;
    logic [`KICK_DATA_BITS-1:0] high_word;
    logic                       err_q;

    // Valid opener: an in-range LOW write
    assign low_ok  = cmd.write && cmd_in_range && !cmd_high;
    // Valid closer: an in-range HIGH write to the latched channel
    assign high_ok = cmd.write && cmd_in_range && cmd_high && (cmd_chan == lat_chan);

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            kickoff_pkg::RTR_IDLE: begin
                // Good or bad, every command is answered from RESPOND_LOW
                if (cmd_fire) begin
                    next_state = kickoff_pkg::RTR_RESPOND_LOW;
                end
            end
            kickoff_pkg::RTR_RESPOND_LOW: begin
                if (rsp_ready) begin
                    next_state = err_q ? kickoff_pkg::RTR_IDLE : kickoff_pkg::RTR_WAIT_HIGH;
                end
            end
            kickoff_pkg::RTR_WAIT_HIGH: begin
                if (cmd_fire) begin
                    next_state = high_ok ? kickoff_pkg::RTR_ROUTE
                                         : kickoff_pkg::RTR_RESPOND_HIGH;
                end
            end
            kickoff_pkg::RTR_ROUTE: begin
                // Held here while the slot is still full
                if (slot_ready[lat_chan]) begin
                    next_state = kickoff_pkg::RTR_RESPOND_HIGH;
                end
            end
            kickoff_pkg::RTR_RESPOND_HIGH: begin
                if (rsp_ready) begin
                    next_state = kickoff_pkg::RTR_IDLE;
                end
            end
            default: next_state = kickoff_pkg::RTR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= kickoff_pkg::RTR_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Capture of channel, data words and the error verdict
    always_ff @(posedge clk) begin
        if (state == kickoff_pkg::RTR_IDLE && cmd_fire) begin
            err_q <= !low_ok;
            if (low_ok) begin
                lat_chan <= cmd_chan;
                low_word <= cmd.wdata;
            end
        end
        // Failed closer drops the pair, state returns to IDLE after the error
        if (state == kickoff_pkg::RTR_WAIT_HIGH && cmd_fire) begin
            err_q <= !high_ok;
            if (high_ok) begin
                high_word <= cmd.wdata;
            end
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    assign cmd_ready = (state == kickoff_pkg::RTR_IDLE) || (state == kickoff_pkg::RTR_WAIT_HIGH);
    assign rsp_valid = (state == kickoff_pkg::RTR_RESPOND_LOW) ||
                       (state == kickoff_pkg::RTR_RESPOND_HIGH);
    assign rsp.err   = err_q;

    // Only the latched channel sees valid, and only in ROUTE
    always_comb begin
        slot_valid = '0;
        if (state == kickoff_pkg::RTR_ROUTE) begin
            slot_valid[lat_chan] = 1'b1;
        end
    end

    assign slot_addr = {high_word, low_word};

endmodule

// File: hdl/launch_arbiter.sv
/* Per-channel pending descriptor slots and a round-robin launch stream
   with back-pressure from the descriptor engines */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module launch_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    // Slot fill handshake from the router
    input  logic [`KICK_NUM_CHANNELS-1:0] slot_valid,
    output logic [`KICK_NUM_CHANNELS-1:0] slot_ready,
    input  logic [`KICK_DESC_BITS-1:0]    slot_addr,
    // Launch stream
    output logic                          launch_valid,
    output kickoff_pkg::launch_t          launch,
    input  logic                          launch_ready
);

    logic [`KICK_NUM_CHANNELS-1:0] slot_busy;
    logic [`KICK_DESC_BITS-1:0]    slot_addr_q [`KICK_NUM_CHANNELS];
    logic [`KICK_CHAN_BITS-1:0]    last_chan;
    logic [`KICK_NUM_CHANNELS-1:0] free_mask;
    logic [`KICK_NUM_CHANNELS-1:0] candidates;
    logic                          pick_found;
    logic [`KICK_CHAN_BITS-1:0]    pick_chan;
    logic                          load_en;

    // Empty slot can take a new address
    assign slot_ready = ~slot_busy;

    // Slot leaving on this cycle's accepted launch
    always_comb begin
        free_mask = '0;
        if (launch_valid && launch_ready) begin
            free_mask[launch.chan] = 1'b1;
        end
    end

    assign candidates = slot_busy & ~free_mask;
    // Output register is empty or drains this cycle
    assign load_en    = !launch_valid || launch_ready;

    // Round-robin search, starting just after the last picked channel
    always_comb begin : rr_pick
        logic [`KICK_CHAN_BITS-1:0] idx;
        pick_found = 1'b0;
        pick_chan  = '0;
        for (int k = 1; k <= `KICK_NUM_CHANNELS; k++) begin
            idx = last_chan + `KICK_CHAN_BITS'(k);
            if (!pick_found && candidates[idx]) begin
                pick_found = 1'b1;
                pick_chan  = idx;
            end
        end
    end

    // Busy flags, launch valid and the round-robin pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_busy    <= '0;
            launch_valid <= 1'b0;
            last_chan    <= '1;
        end else begin
            for (int ch = 0; ch < `KICK_NUM_CHANNELS; ch++) begin
                if (free_mask[ch]) begin
                    slot_busy[ch] <= 1'b0;
                end else if (slot_valid[ch] && slot_ready[ch]) begin
                    slot_busy[ch] <= 1'b1;
                end
            end
            if (load_en) begin
                launch_valid <= pick_found;
                if (pick_found) begin
                    last_chan <= pick_chan;
                end
            end
        end
    end

    // Slot addresses and the registered launch payload
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `KICK_NUM_CHANNELS; ch++) begin
            if (slot_valid[ch] && slot_ready[ch]) begin
                slot_addr_q[ch] <= slot_addr;
            end
        end
        // Payload held while launch_ready is low
        if (load_en && pick_found) begin
            launch.chan <= pick_chan;
            launch.addr <= slot_addr_q[pick_chan];
        end
    end

endmodule

// File: hdl/kickoff_top.sv
/* Top level of the kick-off path: Wishbone adapter, router, launch arbiter */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module kickoff_top (
    input  logic                       clk,
    input  logic                       rst,
    // Wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`KICK_ADDR_BITS-1:0] wb_adr,
    input  logic [`KICK_DATA_BITS-1:0] wb_dat_w,
    output logic                       wb_ack,
    output logic                       wb_err,
    // Launch stream toward the descriptor engines
    output logic                       launch_valid,
    output kickoff_pkg::launch_t       launch,
    input  logic                       launch_ready
);

    // Adapter and router command/response exchange
    logic                   cmd_valid;
    logic                   cmd_ready;
    kickoff_pkg::kick_cmd_t cmd;
    logic                   rsp_valid;
    logic                   rsp_ready;
    kickoff_pkg::kick_rsp_t rsp;

    // Router to arbiter slot handshake
    logic [`KICK_NUM_CHANNELS-1:0] slot_valid;
    logic [`KICK_NUM_CHANNELS-1:0] slot_ready;
    logic [`KICK_DESC_BITS-1:0]    slot_addr;

    wb_cmd_adapter adapter_i (.*);

    kickoff_router router_i (.*);

    launch_arbiter arbiter_i (.*);

endmodule

// File: verif/kickoff_assertions.sv
/* Concurrent checks on the router handshakes and the launch stream
   with the bind into the top level */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module kickoff_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          cmd_ready,
    input logic                          rsp_valid,
    input logic                          rsp_ready,
    input logic [`KICK_NUM_CHANNELS-1:0] slot_valid,
    input logic                          launch_valid,
    input logic                          launch_ready,
    input kickoff_pkg::launch_t          launch
);

    // Number of failed assertions
    int fail_count = 0;

    // At most one channel is offered an address
    slot_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(slot_valid))
        else begin
            $error("slot_valid has more than one bit set: %b", slot_valid);
            fail_count++;
        end

    // Router never takes a command while a response is out
    cmd_rsp_excl: assert property (@(posedge clk) disable iff (rst) !(cmd_ready && rsp_valid))
        else begin
            $error("cmd_ready and rsp_valid high together");
            fail_count++;
        end

    // Stalled launch keeps its payload
    launch_hold: assert property (@(posedge clk) disable iff (rst)
        launch_valid && !launch_ready |=> launch_valid && $stable(launch))
        else begin
            $error("launch stream changed while stalled");
            fail_count++;
        end

    // Response stays up until taken
    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid)
        else begin
            $error("rsp_valid dropped before rsp_ready");
            fail_count++;
        end

endmodule

bind kickoff_top kickoff_assertions kickoff_assertions_i (
    .clk          (clk),
    .rst          (rst),
    .cmd_ready    (cmd_ready),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .slot_valid   (slot_valid),
    .launch_valid (launch_valid),
    .launch_ready (launch_ready),
    .launch       (launch)
);

// File: verif/kickoff_tb.sv
/* Kick-off path testbench with clock and reset, Wishbone host tasks,
   pairing model with expected launches, directed and random tests */
`timescale 1ns/1ns
`include "kickoff_params.svh"

module kickoff_tb;

    localparam int WINDOW        = `KICK_WINDOW_BYTES;
    localparam int MAX_TRANSFERS = 400;

    logic                       clk;
    logic                       rst;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`KICK_ADDR_BITS-1:0] wb_adr;
    logic [`KICK_DATA_BITS-1:0] wb_dat_w;
    logic                       wb_ack;
    logic                       wb_err;
    logic                       launch_valid;
    kickoff_pkg::launch_t       launch;
    logic                       launch_ready;

    integer seed = 32'heeba;
    int     errors;
    int     checks;
    int     tests;
    int     ready_mode;
    logic   xfer_done;

    // Model pairing state and owed launches in arrival order
    logic                       model_waiting;
    logic [`KICK_CHAN_BITS-1:0] model_chan;
    logic [`KICK_DATA_BITS-1:0] model_low;
    kickoff_pkg::launch_t       pending [$];

    kickoff_top kickoff_top_i (.*);

    always #20 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [`KICK_ADDR_BITS-1:0] reg_addr(
        input logic [`KICK_CHAN_BITS-1:0] chan,
        input logic                       high
    );
        logic [`KICK_ADDR_BITS-1:0] a;
        a = '0;
        a[`KICK_CHAN_LSB +: `KICK_CHAN_BITS] = chan;
        a[`KICK_HIGH_BIT] = high;
        return a;
    endfunction

    // Predicts err for one transfer and advances the pairing state
    function automatic logic model_step(
        input logic                       we,
        input logic [`KICK_ADDR_BITS-1:0] adr,
        input logic [`KICK_DATA_BITS-1:0] data
    );
        logic                       in_range;
        logic [`KICK_CHAN_BITS-1:0] chan;
        kickoff_pkg::launch_t       entry;
        in_range = int'(adr) < WINDOW;
        chan     = adr[`KICK_CHAN_LSB +: `KICK_CHAN_BITS];
        if (!model_waiting) begin
            if (we && in_range && !adr[`KICK_HIGH_BIT]) begin
                model_waiting = 1'b1;
                model_chan    = chan;
                model_low     = data;
                return 1'b0;
            end
            return 1'b1;
        end
        // Any second command closes or drops the pair
        model_waiting = 1'b0;
        if (we && in_range && adr[`KICK_HIGH_BIT] && chan == model_chan) begin
            entry.chan = chan;
            entry.addr = {data, model_low};
            pending.push_back(entry);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // One Wishbone classic cycle with stb dropped right after ack or err
    task automatic bus_cycle(
        input  logic                       we,
        input  logic [`KICK_ADDR_BITS-1:0] adr,
        input  logic [`KICK_DATA_BITS-1:0] data,
        output logic                       ack,
        output logic                       err
    );
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        do @(negedge clk); while (!(wb_ack || wb_err));
        ack    = wb_ack;
        err    = wb_err;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic do_xfer(
        input logic                       we,
        input logic [`KICK_ADDR_BITS-1:0] adr,
        input logic [`KICK_DATA_BITS-1:0] data
    );
        logic exp_err;
        logic got_ack;
        logic got_err;
        exp_err = model_step(we, adr, data);
        bus_cycle(we, adr, data, got_ack, got_err);
        checks += 2;
        assert (got_err == exp_err) else begin
            $display("mismatch at %0t: wb_err got %0b expected %0b (adr %h we %0b)",
                     $time, got_err, exp_err, adr, we);
            errors++;
        end
        assert (got_ack == !exp_err) else begin
            $display("mismatch at %0t: wb_ack got %0b expected %0b (adr %h we %0b)",
                     $time, got_ack, !exp_err, adr, we);
            errors++;
        end
    endtask

    // LOW then HIGH write of a random address to one channel
    task automatic kick(input logic [`KICK_CHAN_BITS-1:0] chan);
        do_xfer(1'b1, reg_addr(chan, 1'b0), rand32());
        do_xfer(1'b1, reg_addr(chan, 1'b1), rand32());
    endtask

    // Releases back-pressure and waits for every owed launch
    task automatic drain_launches();
        int waited;
        ready_mode = 1;
        waited     = 0;
        while (pending.size() != 0 && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (pending.size() == 0) else begin
            $display("%0d expected launches never appeared by %0t", pending.size(), $time);
            errors++;
        end
        // Room for a stray duplicate to show up
        repeat (6) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests++;
        $display("%s: %s (%0d errors)", name,
                 (errors == errs_at_start) ? "ok" : "FAILED", errors - errs_at_start);
    endtask

    // ==================================================
    // Launch monitor and back-pressure driver
    // ==================================================

    always @(posedge clk) begin : launch_monitor
        int idx;
        if (!rst && launch_valid && launch_ready) begin
            idx = -1;
            for (int i = 0; i < pending.size(); i++) begin
                if (idx < 0 && pending[i].chan == launch.chan) begin
                    idx = i;
                end
            end
            checks++;
            assert (idx >= 0) else begin
                $display("unexpected launch on channel %0d at %0t", launch.chan, $time);
                errors++;
            end
            if (idx >= 0) begin
                assert (launch.addr == pending[idx].addr) else begin
                    $display("mismatch at %0t: launch.addr ch %0d got %h expected %h",
                             $time, launch.chan, launch.addr, pending[idx].addr);
                    errors++;
                end
                pending.delete(idx);
            end
        end
    end

    // Mode 0 holds low, 1 holds high, 2 is random
    always @(negedge clk) begin : ready_driver
        logic [31:0] r;
        r = rand32();
        case (ready_mode)
            0: launch_ready = 1'b0;
            1: launch_ready = 1'b1;
            default: launch_ready = r[0];
        endcase
    end

    initial begin : watchdog
        repeat (MAX_TRANSFERS * 200) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", MAX_TRANSFERS * 200);
        $display("Test failures found");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin : main
        int          mark;
        logic [31:0] r;
        logic        we;
        logic [`KICK_ADDR_BITS-1:0] adr;
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        launch_ready = 1'b0;
        ready_mode = 1;
        model_waiting = 1'b0;
        model_chan = '0;
        model_low = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        checks++;
        assert (!wb_ack && !wb_err && !launch_valid) else begin
            $display("outputs not low after reset at %0t", $time);
            errors++;
        end

        // Valid pairs on random channels
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            kick(r[`KICK_CHAN_BITS-1:0]);
        end
        drain_launches();
        end_test("valid pairs", mark);

        // Errors from the idle state
        mark = errors;
        do_xfer(1'b0, reg_addr(2, 1'b0), '0);
        r = rand32();
        do_xfer(1'b1, 12'(WINDOW + int'(r[7:0])), rand32());
        do_xfer(1'b1, 12'hffc, rand32());
        do_xfer(1'b1, reg_addr(5, 1'b1), rand32());
        drain_launches();
        end_test("idle errors", mark);

        // Broken pairs and a check that each pending low word is gone
        mark = errors;
        do_xfer(1'b1, reg_addr(1, 1'b0), rand32());
        do_xfer(1'b0, reg_addr(1, 1'b0), '0);
        do_xfer(1'b1, reg_addr(1, 1'b1), rand32());
        do_xfer(1'b1, reg_addr(3, 1'b0), rand32());
        do_xfer(1'b1, reg_addr(4, 1'b0), rand32());
        do_xfer(1'b1, reg_addr(3, 1'b1), rand32());
        do_xfer(1'b1, reg_addr(6, 1'b0), rand32());
        do_xfer(1'b1, reg_addr(7, 1'b1), rand32());
        kick(6);
        drain_launches();
        end_test("broken pairs", mark);

        // Back-pressure fills every slot and then stalls on a full one
        mark = errors;
        ready_mode = 0;
        for (int ch = 0; ch < `KICK_NUM_CHANNELS; ch++) begin
            kick(`KICK_CHAN_BITS'(ch));
        end
        xfer_done = 1'b0;
        fork
            begin
                kick(0);
                xfer_done = 1'b1;
            end
            begin
                repeat (30) @(negedge clk);
                checks++;
                assert (!xfer_done) else begin
                    $display("kick-off to full channel 0 finished while launch_ready was low");
                    errors++;
                end
                ready_mode = 1;
            end
        join
        drain_launches();
        end_test("back-pressure", mark);

        // Random mix with random launch_ready
        mark = errors;
        ready_mode = 2;
        for (int i = 0; i < 300; i++) begin
            r = rand32();
            if (model_waiting && r[3:0] < 4'd10) begin
                we  = 1'b1;
                adr = reg_addr(model_chan, 1'b1);
            end else begin
                we = (r[6:4] != 3'd0);
                if (r[9:7] == 3'd0) begin
                    adr = 12'(WINDOW + int'(r[17:10]));
                end else begin
                    adr = reg_addr(r[12 +: `KICK_CHAN_BITS], r[20]);
                end
            end
            do_xfer(we, adr, rand32());
        end
        drain_launches();
        end_test("random mix", mark);

        // Failed handshake assertions of the bound checker
        errors += kickoff_top_i.kickoff_assertions_i.fail_count;

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hdl
hdl/kickoff_pkg.sv
hdl/wb_cmd_adapter.sv
hdl/kickoff_router.sv
hdl/launch_arbiter.sv
hdl/kickoff_top.sv
verif/kickoff_assertions.sv
verif/kickoff_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the kick-off testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module kickoff_tb -f files.f -o kickoff_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/kickoff_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
